/* hw/div_ctrl_pkg.sv */
package div_ctrl_pkg;

    // ==================
    // Operation control
    // ==================

    typedef enum logic [1:0] {
        RNE = 2'd0,
        RDN = 2'd1,
        RUP = 2'd2,
        RTZ = 2'd3
    } round_mode_e;

    typedef struct packed {
        logic invalid;
        logic div_by_zero;
        logic overflow;
        logic underflow;
        logic inexact;
    } fp_flags_t;

    // ==================
    // Datapath working types
    // ==================

    // Signed so the range check sees negative exponents
    typedef logic signed [16:0] wide_exp_t;

    // 64 mantissa bits plus integer headroom and guard/sticky
    typedef logic [66:0] quot_t;

    // Classifier verdict
    typedef struct packed {
        logic            hit;
        fp80_pkg::fp80_t result;
        fp_flags_t       flags;
    } special_t;

    typedef enum logic [1:0] {
        IDLE,
        CLASSIFY,
        DIVIDE,
        FINISH
    } seq_state_e;

endpackage

/* hw/div_sequencer.sv */
module div_sequencer (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      start,
    input  fp80_pkg::fp80_t           operand_a,
    input  fp80_pkg::fp80_t           operand_b,
    input  div_ctrl_pkg::round_mode_e round_mode,
    input  div_ctrl_pkg::special_t    special,
    input  fp80_pkg::fp_sign_t        res_sign,
    input  logic                      div_valid,
    input  fp80_pkg::fp80_t           packed_result,
    input  div_ctrl_pkg::fp_flags_t   packed_flags,
    output fp80_pkg::fp80_t           cap_a,
    output fp80_pkg::fp80_t           cap_b,
    output div_ctrl_pkg::round_mode_e cap_mode,
    output logic                      div_start,
    output div_ctrl_pkg::wide_exp_t   wexp,
    output fp80_pkg::fp80_t           result,
    output div_ctrl_pkg::fp_flags_t   flags,
    output logic                      done
);

    div_ctrl_pkg::seq_state_e state;
    div_ctrl_pkg::wide_exp_t  wexp_next;

    // Exp A minus exp B plus bias, kept signed
    assign wexp_next = div_ctrl_pkg::wide_exp_t'({2'b00, cap_a.exp})
                     - div_ctrl_pkg::wide_exp_t'({2'b00, cap_b.exp})
                     + div_ctrl_pkg::wide_exp_t'(fp80_pkg::EXP_BIAS);

    // Divider kicks off straight from CLASSIFY
    assign div_start = (state == div_ctrl_pkg::CLASSIFY) && !special.hit;

    // ==================
    // Control FSM
    // ==================

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state  <= div_ctrl_pkg::IDLE;
            done   <= 1'b0;
            result <= '0;
            flags  <= '0;
        end else begin
            done <= 1'b0;
            case (state)
                div_ctrl_pkg::IDLE: begin
                    if (start) begin
                        state <= div_ctrl_pkg::CLASSIFY;
                    end
                end
                div_ctrl_pkg::CLASSIFY: begin
                    if (special.hit) begin
                        result <= special.result;
                        flags  <= special.flags;
                        done   <= 1'b1;
                        state  <= div_ctrl_pkg::IDLE;
                    end else begin
                        state <= div_ctrl_pkg::DIVIDE;
                    end
                end
                div_ctrl_pkg::DIVIDE: begin
                    if (div_valid) begin
                        state <= div_ctrl_pkg::FINISH;
                    end
                end
                div_ctrl_pkg::FINISH: begin
                    // Sign from the classifier, magnitude from the rounder
                    result <= '{sign: res_sign, exp: packed_result.exp,
                                mant: packed_result.mant};
                    flags  <= packed_flags;
                    done   <= 1'b1;
                    state  <= div_ctrl_pkg::IDLE;
                end
                default: state <= div_ctrl_pkg::IDLE;
            endcase
        end
    end

    // Operand capture, start ignored while busy
    always_ff @(posedge clk) begin
        if (state == div_ctrl_pkg::IDLE && start) begin
            cap_a    <= operand_a;
            cap_b    <= operand_b;
            cap_mode <= round_mode;
        end
        if (state == div_ctrl_pkg::CLASSIFY) begin
            wexp <= wexp_next;
        end
    end

endmodule

/* hw/fp80_classify.sv */
module fp80_classify (
    input  fp80_pkg::fp80_t        a,
    input  fp80_pkg::fp80_t        b,
    output div_ctrl_pkg::special_t special,
    output fp80_pkg::fp_sign_t     res_sign
);

    fp80_pkg::fp_class_e cls_a;
    fp80_pkg::fp_class_e cls_b;
    fp80_pkg::fp80_t     inf_res;
    fp80_pkg::fp80_t     zero_res;

    function automatic fp80_pkg::fp_class_e classify(input fp80_pkg::fp80_t x);
        if (x.exp == '0) begin
            // Denormals are flushed along with true zero
            return fp80_pkg::ZERO;
        end
        if (x.exp == fp80_pkg::fp_exp_t'(fp80_pkg::EXP_MAX)) begin
            if (x.mant == fp80_pkg::MANT_ONE) begin
                return fp80_pkg::INF;
            end
            return fp80_pkg::NAN;
        end
        return fp80_pkg::NORMAL;
    endfunction

    assign cls_a    = classify(a);
    assign cls_b    = classify(b);
    assign res_sign = a.sign ^ b.sign;

    assign inf_res  = '{sign: res_sign, exp: fp80_pkg::fp_exp_t'(fp80_pkg::EXP_MAX),
                        mant: fp80_pkg::MANT_ONE};
    assign zero_res = '{sign: res_sign, exp: '0, mant: '0};

    // ==================
    // Special-case priority
    // ==================

    always_comb begin
        special = '0;
        if (cls_a == fp80_pkg::NAN || cls_b == fp80_pkg::NAN) begin
            special.hit           = 1'b1;
            special.result        = fp80_pkg::CANON_NAN;
            special.flags.invalid = 1'b1;
        end else if ((cls_a == fp80_pkg::ZERO && cls_b == fp80_pkg::ZERO) ||
                     (cls_a == fp80_pkg::INF && cls_b == fp80_pkg::INF)) begin
            special.hit           = 1'b1;
            special.result        = fp80_pkg::CANON_NAN;
            special.flags.invalid = 1'b1;
        end else if (cls_b == fp80_pkg::ZERO) begin
            special.hit               = 1'b1;
            special.result            = inf_res;
            special.flags.div_by_zero = 1'b1;
        end else if (cls_a == fp80_pkg::INF) begin
            special.hit    = 1'b1;
            special.result = inf_res;
        end else if (cls_a == fp80_pkg::ZERO || cls_b == fp80_pkg::INF) begin
            // 0/x and x/inf both collapse to signed zero
            special.hit    = 1'b1;
            special.result = zero_res;
        end
    end

endmodule

/* hw/fp80_div_top.sv */
module fp80_div_top #(
    parameter int MANT_W = fp80_pkg::MANT_W
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      start,
    input  fp80_pkg::fp80_t           operand_a,
    input  fp80_pkg::fp80_t           operand_b,
    input  div_ctrl_pkg::round_mode_e round_mode,
    output fp80_pkg::fp80_t           result,
    output div_ctrl_pkg::fp_flags_t   flags,
    output logic                      done
);

    fp80_pkg::fp80_t           cap_a;
    fp80_pkg::fp80_t           cap_b;
    div_ctrl_pkg::round_mode_e cap_mode;
    div_ctrl_pkg::special_t    special;
    fp80_pkg::fp_sign_t        res_sign;
    div_ctrl_pkg::wide_exp_t   wexp;
    logic                      div_start;
    logic                      div_valid;
    logic                      sticky;
    div_ctrl_pkg::quot_t       quotient;
    fp80_pkg::fp80_t           packed_result;
    div_ctrl_pkg::fp_flags_t   packed_flags;

    div_sequencer u_seq (
        .clk           (clk),
        .reset         (reset),
        .start         (start),
        .operand_a     (operand_a),
        .operand_b     (operand_b),
        .round_mode    (round_mode),
        .special       (special),
        .res_sign      (res_sign),
        .div_valid     (div_valid),
        .packed_result (packed_result),
        .packed_flags  (packed_flags),
        .cap_a         (cap_a),
        .cap_b         (cap_b),
        .cap_mode      (cap_mode),
        .div_start     (div_start),
        .wexp          (wexp),
        .result        (result),
        .flags         (flags),
        .done          (done)
    );

    fp80_classify u_classify (
        .a        (cap_a),
        .b        (cap_b),
        .special  (special),
        .res_sign (res_sign)
    );

    mant_divider #(
        .MANT_W (MANT_W)
    ) u_divider (
        .clk       (clk),
        .reset     (reset),
        .div_start (div_start),
        .dividend  (cap_a.mant),
        .divisor   (cap_b.mant),
        .div_valid (div_valid),
        .quotient  (quotient),
        .sticky    (sticky)
    );

    fp80_round_pack u_round (
        .sign          (res_sign),
        .wexp          (wexp),
        .quotient      (quotient),
        .rem_sticky    (sticky),
        .mode          (cap_mode),
        .packed_result (packed_result),
        .packed_flags  (packed_flags)
    );

endmodule

/* hw/fp80_pkg.sv */
package fp80_pkg;

    // ==================
    // x87 extended field types
    // ==================

    typedef logic        fp_sign_t;
    typedef logic [14:0] fp_exp_t;
    // Explicit integer bit at the top
    typedef logic [63:0] fp_mant_t;

    typedef struct packed {
        fp_sign_t sign;
        fp_exp_t  exp;
        fp_mant_t mant;
    } fp80_t;

    // Operand classes, denormals fold into ZERO
    typedef enum logic [1:0] {
        ZERO   = 2'd0,
        INF    = 2'd1,
        NAN    = 2'd2,
        NORMAL = 2'd3
    } fp_class_e;

    // ==================
    // Constants
    // ==================

    localparam int EXP_BIAS = 16383;
    localparam int EXP_MAX  = 32767;
    localparam int MANT_W   = 64;

    // Mantissa 1.000, integer bit alone
    localparam fp_mant_t MANT_ONE = 64'h8000_0000_0000_0000;

    // Quiet NaN with integer bit and top fraction bit set
    localparam fp80_t CANON_NAN = '{
        sign: 1'b0,
        exp:  15'h7FFF,
        mant: 64'hC000_0000_0000_0000
    };

endpackage

/* hw/fp80_round_pack.sv */
module fp80_round_pack (
    input  fp80_pkg::fp_sign_t        sign,
    input  div_ctrl_pkg::wide_exp_t   wexp,
    input  div_ctrl_pkg::quot_t       quotient,
    input  logic                      rem_sticky,
    input  div_ctrl_pkg::round_mode_e mode,
    output fp80_pkg::fp80_t           packed_result,
    output div_ctrl_pkg::fp_flags_t   packed_flags
);

    localparam int Q_W   = $bits(div_ctrl_pkg::quot_t);
    localparam int M_W   = fp80_pkg::MANT_W;
    localparam int E_W   = $bits(fp80_pkg::fp_exp_t);
    // Guard sits just below the kept mantissa
    localparam int GUARD = Q_W - M_W - 1;

    div_ctrl_pkg::quot_t     norm_q;
    div_ctrl_pkg::wide_exp_t norm_exp;
    fp80_pkg::fp_mant_t      mant;
    logic                    guard;
    logic                    sticky;
    logic                    round_inc;
    logic [M_W:0]            sum;
    fp80_pkg::fp_mant_t      final_mant;
    div_ctrl_pkg::wide_exp_t final_exp;

    // ==================
    // Normalize
    // ==================

    // Leading one is at the top bit or the one below it
    always_comb begin
        if (quotient[Q_W-1]) begin
            norm_q   = quotient;
            norm_exp = wexp;
        end else begin
            norm_q   = quotient << 1;
            norm_exp = wexp - div_ctrl_pkg::wide_exp_t'(1);
        end
    end

    assign mant   = norm_q[Q_W-1 -: M_W];
    assign guard  = norm_q[GUARD];
    assign sticky = (|norm_q[GUARD-1:0]) | rem_sticky;

    // ==================
    // Round
    // ==================

    always_comb begin
        case (mode)
            div_ctrl_pkg::RNE: round_inc = guard & (sticky | mant[0]);
            div_ctrl_pkg::RDN: round_inc = sign & (guard | sticky);
            div_ctrl_pkg::RUP: round_inc = ~sign & (guard | sticky);
            div_ctrl_pkg::RTZ: round_inc = 1'b0;
        endcase
    end

    assign sum = {1'b0, mant} + {{M_W{1'b0}}, round_inc};

    // Carry out means all ones rolled over to 1.000
    always_comb begin
        if (sum[M_W]) begin
            final_mant = fp80_pkg::MANT_ONE;
            final_exp  = norm_exp + div_ctrl_pkg::wide_exp_t'(1);
        end else begin
            final_mant = sum[M_W-1:0];
            final_exp  = norm_exp;
        end
    end

    // ==================
    // Range check and pack
    // ==================

    always_comb begin
        packed_flags         = '0;
        packed_flags.inexact = guard | sticky;
        if (final_exp > div_ctrl_pkg::wide_exp_t'(fp80_pkg::EXP_MAX - 1)) begin
            packed_result = '{sign: sign, exp: fp80_pkg::fp_exp_t'(fp80_pkg::EXP_MAX),
                              mant: fp80_pkg::MANT_ONE};
            packed_flags.overflow = 1'b1;
            packed_flags.inexact  = 1'b1;
        end else if (final_exp < div_ctrl_pkg::wide_exp_t'(1)) begin
            // Flush to signed zero, no denormal output
            packed_result          = '{sign: sign, exp: '0, mant: '0};
            packed_flags.underflow = 1'b1;
            packed_flags.inexact   = 1'b1;
        end else begin
            packed_result = '{sign: sign, exp: final_exp[E_W-1:0], mant: final_mant};
        end
    end

endmodule

/* hw/mant_divider.sv */
module mant_divider #(
    parameter int MANT_W = fp80_pkg::MANT_W
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                div_start,
    input  logic [MANT_W-1:0]   dividend,
    input  logic [MANT_W-1:0]   divisor,
    output logic                div_valid,
    output div_ctrl_pkg::quot_t quotient,
    output logic                sticky
);

    localparam int Q_W   = $bits(div_ctrl_pkg::quot_t);
    localparam int CNT_W = $clog2(Q_W);

    logic [MANT_W-1:0]   divisor_q;
    logic [MANT_W:0]     rem_q;
    div_ctrl_pkg::quot_t quot_q;
    logic [CNT_W-1:0]    cnt_q;
    logic                busy_q;

    logic                first_ge;
    logic [MANT_W:0]     first_rem;
    logic [MANT_W:0]     trial;
    logic                step_ge;
    logic [MANT_W:0]     step_rem;

    // Top quotient bit on the load edge; the upper dividend bits alone
    // are always below the divisor, so the long division starts here
    assign first_ge  = (dividend >= divisor);
    assign first_rem = first_ge ? {1'b0, dividend - divisor} : {1'b0, dividend};

    // Shift in a zero, try to subtract
    assign trial    = {rem_q[MANT_W-1:0], 1'b0};
    assign step_ge  = (trial >= {1'b0, divisor_q});
    assign step_rem = step_ge ? trial - {1'b0, divisor_q} : trial;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy_q    <= 1'b0;
            cnt_q     <= '0;
            div_valid <= 1'b0;
        end else begin
            div_valid <= 1'b0;
            if (div_start) begin
                busy_q <= 1'b1;
                cnt_q  <= CNT_W'(Q_W - 1);
            end else if (busy_q) begin
                cnt_q <= cnt_q - 1'b1;
                if (cnt_q == CNT_W'(1)) begin
                    busy_q    <= 1'b0;
                    div_valid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (div_start) begin
            divisor_q <= divisor;
            rem_q     <= first_rem;
            quot_q    <= div_ctrl_pkg::quot_t'(first_ge);
        end else if (busy_q) begin
            rem_q  <= step_rem;
            quot_q <= {quot_q[Q_W-2:0], step_ge};
        end
    end

    assign quotient = quot_q;
    assign sticky   = |rem_q;

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the fp80 divider testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps \
    -f sources.f \
    --top-module tb_fp80_div \
    -Mdir obj_dir \
    -o tb_fp80_div

./obj_dir/tb_fp80_div | tee "$LOG"

if grep -q "TEST FAILED" "$LOG"; then
    echo "simulation reported failure, see $LOG"
    exit 1
fi

echo "simulation log clean, see $LOG"

/* sources.f */
+incdir+tests
hw/fp80_pkg.sv
hw/div_ctrl_pkg.sv
hw/fp80_classify.sv
hw/mant_divider.sv
hw/fp80_round_pack.sv
hw/div_sequencer.sv
hw/fp80_div_top.sv
tests/tb_fp80_div.sv

/* tests/tb_fp80_vectors.svh */
`ifndef TB_FP80_VECTORS_SVH
`define TB_FP80_VECTORS_SVH

// Row: operand_a, operand_b, round_mode, then expected result, expected flags
// Flag bits: invalid, div_by_zero, overflow, underflow, inexact

localparam int NUM_VECS = 24;

localparam vec_t VECTORS [NUM_VECS] = '{
    // Special cases
    '{80'h7fff_c000_0000_0000_0000, 80'h3fff_8000_0000_0000_0000, div_ctrl_pkg::RNE,
      80'h7fff_c000_0000_0000_0000, 5'b10000},
    '{80'h0000_0000_0000_0000_0000, 80'h0000_0000_0000_0000_0000, div_ctrl_pkg::RNE,
      80'h7fff_c000_0000_0000_0000, 5'b10000},
    '{80'h7fff_8000_0000_0000_0000, 80'h7fff_8000_0000_0000_0000, div_ctrl_pkg::RNE,
      80'h7fff_c000_0000_0000_0000, 5'b10000},
    '{80'h4001_a000_0000_0000_0000, 80'h0000_0000_0000_0000_0000, div_ctrl_pkg::RNE,
      80'h7fff_8000_0000_0000_0000, 5'b01000},
    '{80'hc001_a000_0000_0000_0000, 80'h0000_0000_0000_0000_0000, div_ctrl_pkg::RNE,
      80'hffff_8000_0000_0000_0000, 5'b01000},
    '{80'h7fff_8000_0000_0000_0000, 80'h4000_8000_0000_0000_0000, div_ctrl_pkg::RNE,
      80'h7fff_8000_0000_0000_0000, 5'b00000},
    '{80'h7fff_8000_0000_0000_0000, 80'hc000_8000_0000_0000_0000, div_ctrl_pkg::RNE,
      80'hffff_8000_0000_0000_0000, 5'b00000},
    '{80'h0000_0000_0000_0000_0000, 80'h4000_c000_0000_0000_0000, div_ctrl_pkg::RNE,
      80'h0000_0000_0000_0000_0000, 5'b00000},
    '{80'h4000_c000_0000_0000_0000, 80'h7fff_8000_0000_0000_0000, div_ctrl_pkg::RNE,
      80'h0000_0000_0000_0000_0000, 5'b00000},
    '{80'hc000_c000_0000_0000_0000, 80'h7fff_8000_0000_0000_0000, div_ctrl_pkg::RNE,
      80'h8000_0000_0000_0000_0000, 5'b00000},
    // Exact quotients: 6/3, -1/0.5, 1.5/1.5
    '{80'h4001_c000_0000_0000_0000, 80'h4000_c000_0000_0000_0000, div_ctrl_pkg::RNE,
      80'h4000_8000_0000_0000_0000, 5'b00000},
    '{80'hbfff_8000_0000_0000_0000, 80'h3ffe_8000_0000_0000_0000, div_ctrl_pkg::RTZ,
      80'hc000_8000_0000_0000_0000, 5'b00000},
    '{80'h3fff_c000_0000_0000_0000, 80'h3fff_c000_0000_0000_0000, div_ctrl_pkg::RUP,
      80'h3fff_8000_0000_0000_0000, 5'b00000},
    // 1/3 in all four modes
    '{80'h3fff_8000_0000_0000_0000, 80'h4000_c000_0000_0000_0000, div_ctrl_pkg::RNE,
      80'h3ffd_aaaa_aaaa_aaaa_aaab, 5'b00001},
    '{80'h3fff_8000_0000_0000_0000, 80'h4000_c000_0000_0000_0000, div_ctrl_pkg::RDN,
      80'h3ffd_aaaa_aaaa_aaaa_aaaa, 5'b00001},
    '{80'h3fff_8000_0000_0000_0000, 80'h4000_c000_0000_0000_0000, div_ctrl_pkg::RUP,
      80'h3ffd_aaaa_aaaa_aaaa_aaab, 5'b00001},
    '{80'h3fff_8000_0000_0000_0000, 80'h4000_c000_0000_0000_0000, div_ctrl_pkg::RTZ,
      80'h3ffd_aaaa_aaaa_aaaa_aaaa, 5'b00001},
    // -1/3, directed modes swap
    '{80'hbfff_8000_0000_0000_0000, 80'h4000_c000_0000_0000_0000, div_ctrl_pkg::RNE,
      80'hbffd_aaaa_aaaa_aaaa_aaab, 5'b00001},
    '{80'hbfff_8000_0000_0000_0000, 80'h4000_c000_0000_0000_0000, div_ctrl_pkg::RDN,
      80'hbffd_aaaa_aaaa_aaaa_aaab, 5'b00001},
    '{80'hbfff_8000_0000_0000_0000, 80'h4000_c000_0000_0000_0000, div_ctrl_pkg::RUP,
      80'hbffd_aaaa_aaaa_aaaa_aaaa, 5'b00001},
    '{80'hbfff_8000_0000_0000_0000, 80'h4000_c000_0000_0000_0000, div_ctrl_pkg::RTZ,
      80'hbffd_aaaa_aaaa_aaaa_aaaa, 5'b00001},
    // Range limits: max/0.5, min/2, exponent difference far below -16383
    '{80'h7ffe_ffff_ffff_ffff_ffff, 80'h3ffe_8000_0000_0000_0000, div_ctrl_pkg::RNE,
      80'h7fff_8000_0000_0000_0000, 5'b00101},
    '{80'h0001_8000_0000_0000_0000, 80'h4000_8000_0000_0000_0000, div_ctrl_pkg::RNE,
      80'h0000_0000_0000_0000_0000, 5'b00011},
    '{80'h8001_8000_0000_0000_0000, 80'h7ffe_8000_0000_0000_0000, div_ctrl_pkg::RNE,
      80'h8000_0000_0000_0000_0000, 5'b00011}
};

`endif

/* tests/tb_fp80_div.sv */
module tb_fp80_div;

    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        fp80_pkg::fp80_t           a;
        fp80_pkg::fp80_t           b;
        div_ctrl_pkg::round_mode_e mode;
        fp80_pkg::fp80_t           exp_result;
        div_ctrl_pkg::fp_flags_t   exp_flags;
    } vec_t;

    `include "tb_fp80_vectors.svh"

    localparam int NUM_RANDOM   = 20;
    localparam int DONE_TIMEOUT = 200;

    logic                      clk;
    logic                      reset;
    logic                      start;
    fp80_pkg::fp80_t           operand_a;
    fp80_pkg::fp80_t           operand_b;
    div_ctrl_pkg::round_mode_e round_mode;
    fp80_pkg::fp80_t           result;
    div_ctrl_pkg::fp_flags_t   flags;
    logic                      done;

    int errors;
    int tests_run;
    int tests_failed;
    bit timed_out;

    fp80_div_top uut (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .operand_a  (operand_a),
        .operand_b  (operand_b),
        .round_mode (round_mode),
        .result     (result),
        .flags      (flags),
        .done       (done)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ====================
    // Compare tasks
    // ====================

    task automatic check_result(input string name, input fp80_pkg::fp80_t got,
                                input fp80_pkg::fp80_t expected);
        if (got !== expected) begin
            $display("ERR %0t ns %s got %h expected %h", $time, name, got, expected);
            errors++;
        end
    endtask

    task automatic check_flags(input string name, input div_ctrl_pkg::fp_flags_t got,
                               input div_ctrl_pkg::fp_flags_t expected);
        if (got !== expected) begin
            $display("ERR %0t ns %s got %b expected %b", $time, name, got, expected);
            errors++;
        end
    endtask

    // Count done pulses up to the first, then watch two more cycles
    task automatic wait_for_done(output bit seen, output int pulses);
        int cycles;
        seen   = 1'b0;
        pulses = 0;
        cycles = 0;
        while (!seen && cycles < DONE_TIMEOUT) begin
            @(negedge clk);
            cycles++;
            if (done) begin
                seen = 1'b1;
                pulses++;
            end
        end
        if (seen) begin
            repeat (2) begin
                @(negedge clk);
                if (done) begin
                    pulses++;
                end
            end
        end
    endtask

    // x with a normal exponent, divided by 1.0 gives x back
    function automatic vec_t random_identity();
        vec_t v;
        v.a.sign     = fp80_pkg::fp_sign_t'($urandom_range(1, 0));
        v.a.exp      = fp80_pkg::fp_exp_t'($urandom_range(31000, 1000));
        v.a.mant     = fp80_pkg::fp_mant_t'({1'b1, 31'($urandom), $urandom});
        v.b          = 80'h3fff_8000_0000_0000_0000;
        v.mode       = div_ctrl_pkg::round_mode_e'($urandom_range(3, 0));
        v.exp_result = v.a;
        v.exp_flags  = '0;
        return v;
    endfunction

    task automatic apply_op(input vec_t v, input string kind);
        bit seen;
        int pulses;
        int errors_before;
        errors_before = errors;
        @(posedge clk);
        start      <= 1'b1;
        operand_a  <= v.a;
        operand_b  <= v.b;
        round_mode <= v.mode;
        @(posedge clk);
        // Operands are captured, so scramble the inputs
        start      <= 1'b0;
        operand_a  <= ~v.a;
        operand_b  <= ~v.b;
        round_mode <= div_ctrl_pkg::round_mode_e'(~v.mode);
        wait_for_done(seen, pulses);
        tests_run++;
        if (!seen) begin
            $display("test %0d %s: done never came within %0d cycles",
                     tests_run, kind, DONE_TIMEOUT);
            timed_out = 1'b1;
            tests_failed++;
        end else begin
            if (pulses != 1) begin
                $display("test %0d: done pulsed %0d times instead of once", tests_run, pulses);
                errors++;
            end
            check_result("result", result, v.exp_result);
            check_flags("flags", flags, v.exp_flags);
            if (errors == errors_before) begin
                $display("test %0d %s a=%h b=%h mode=%0d: ok", tests_run, kind, v.a, v.b, v.mode);
            end else begin
                $display("test %0d %s a=%h b=%h mode=%0d: mismatch",
                         tests_run, kind, v.a, v.b, v.mode);
                tests_failed++;
            end
        end
    endtask

    // ====================
    // Main sequence
    // ====================

    initial begin
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        timed_out    = 1'b0;
        void'($urandom(32'hb9fe_ce89));
        reset      = 1'b1;
        start      = 1'b0;
        operand_a  = '0;
        operand_b  = '0;
        round_mode = div_ctrl_pkg::RNE;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);

        // Idle outputs after reset
        tests_run++;
        if (done !== 1'b0) begin
            $display("done is high right after reset");
            errors++;
        end
        check_result("result", result, '0);
        check_flags("flags", flags, '0);
        if (errors == 0) begin
            $display("test %0d reset: ok", tests_run);
        end else begin
            $display("test %0d reset: mismatch", tests_run);
            tests_failed++;
        end

        for (int i = 0; i < NUM_VECS && !timed_out; i++) begin
            apply_op(VECTORS[i], "table");
        end
        for (int i = 0; i < NUM_RANDOM && !timed_out; i++) begin
            apply_op(random_identity(), "x/1.0");
        end

        $display("%0d tests run, %0d passed, %0d failed",
                 tests_run, tests_run - tests_failed, tests_failed);
        if (timed_out || tests_failed != 0) begin
            $display("TEST FAILED");
        end else begin
            $display("TEST PASSED");
        end
        $finish;
    end

endmodule
